// File: compile.f
+incdir+design
design/characterPkg.sv
design/partDecode.sv
design/partShape.sv
design/layerCompose.sv
design/characterRender.sv
test/characterRenderTb.sv

// File: design/characterPkg.sv
`include "character_consts.svh"

package characterPkg;

  // a screen coordinate.
  typedef struct packed {
    logic [`SCREEN_X_BITS-1:0] x;
    logic [`SCREEN_Y_BITS-1:0] y;
  } pixelPos;

  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } rgbColor;

  // the index doubles as the drawing priority, higher index is drawn on top.
  typedef enum logic [2:0] {
    pants    = 3'd0,
    body     = 3'd1,
    armLeft  = 3'd2,
    armRight = 3'd3,
    head     = 3'd4
  } partIndex;

  // one top-left corner per part, indexed by partIndex.
  typedef pixelPos [`PART_COUNT-1:0] partCorners;

  typedef struct packed {
    logic [`PART_COUNT-1:0]    hit;
    rgbColor [`PART_COUNT-1:0] color;
  } partHits;

  typedef struct packed {
    logic    valid;
    rgbColor color;
  } shadedPixel;

endpackage

// File: design/characterRender.sv
`timescale 1ns/1ps
`include "character_consts.svh"

module characterRender (
  input  logic                     clk,
  input  logic                     rstN,
  input  logic                     enable,
  input  logic                     motionEn,
  input  characterPkg::pixelPos    pixel,
  input  characterPkg::pixelPos    currentCorner,
  input  characterPkg::pixelPos    initCorner,
  output characterPkg::shadedPixel out
);
  import characterPkg::*;

  partCorners corners;
  pixelPos    shapePixel;
  logic       shapeEnable;
  partHits    hits;
  rgbColor    partColors [`PART_COUNT];
  logic       composeValid;
  rgbColor    composeColor;

  // decode, shape and compose each add one register, three cycles in total.
  partDecode decode (
    .clk          (clk),
    .rstN         (rstN),
    .enable       (enable),
    .motionEn     (motionEn),
    .pixel        (pixel),
    .currentCorner(currentCorner),
    .initCorner   (initCorner),
    .corners      (corners),
    .pixelOut     (shapePixel),
    .enableOut    (shapeEnable)
  );

  partShape shape (
    .clk    (clk),
    .rstN   (rstN),
    .enable (shapeEnable),
    .pixel  (shapePixel),
    .corners(corners),
    .hits   (hits)
  );

  for (genvar i = 0; i < `PART_COUNT; i++) begin : gColor
    assign partColors[i] = hits.color[i];
  end

  layerCompose #(.N(`PART_COUNT), .payloadT(rgbColor)) compose (
    .clk      (clk),
    .rstN     (rstN),
    .hitVector(hits.hit),
    .payloads (partColors),
    .valid    (composeValid),
    .winner   (composeColor)
  );

  assign out = '{valid: composeValid, color: composeColor};

endmodule

// File: design/character_consts.svh
`ifndef CHARACTER_CONSTS_SVH
`define CHARACTER_CONSTS_SVH

// screen coordinate widths for a 640x480 raster.
`define SCREEN_X_BITS 10
`define SCREEN_Y_BITS 9

`define PART_COUNT 5

// ######################################
// part offsets from the character's top-left corner.
`define HEAD_OFF_X 0
`define HEAD_OFF_Y 0
`define BODY_OFF_X 0
`define BODY_OFF_Y 100
`define ARM_L_OFF_X (-15)
`define ARM_L_OFF_Y 95
`define ARM_R_OFF_X 90
`define ARM_R_OFF_Y 95
`define PANTS_OFF_X 0
`define PANTS_OFF_Y 152

// ######################################
// part sizes in pixels.
`define HEAD_W 90
`define HEAD_H 100
`define BODY_W 90
`define BODY_H 52
`define ARM_L_W 15
`define ARM_L_H 50
`define ARM_R_W 15
`define ARM_R_H 50
`define PANTS_W 90
`define PANTS_H 40

// part colours as 24'hRRGGBB.
`define HEAD_RGB 24'hF2C9A0
`define BODY_RGB 24'h2E6FD8
`define ARM_L_RGB 24'hE8B080
`define ARM_R_RGB 24'hD89A6A
`define PANTS_RGB 24'h3A2A1C

`endif

// File: design/layerCompose.sv
`timescale 1ns/1ps
`include "character_consts.svh"

module layerCompose #(
  parameter int  N        = `PART_COUNT,
  parameter type payloadT = characterPkg::rgbColor
) (
  input  logic         clk,
  input  logic         rstN,
  input  logic [N-1:0] hitVector,
  input  payloadT      payloads [N],
  output logic         valid,
  output payloadT      winner
);

  logic [N-1:0] oneHot;
  payloadT      selected;

  // ######################################
  // keep only the most significant set bit of the hit vector.
  always_comb begin
    logic found;
    found  = 1'b0;
    oneHot = '0;
    for (int i = N - 1; i >= 0; i--) begin
      if (hitVector[i] && !found) begin
        oneHot[i] = 1'b1;
        found     = 1'b1;
      end
    end
  end

  // with no bit set the selection stays at zero.
  always_comb begin
    selected = '0;
    for (int i = 0; i < N; i++) begin
      if (oneHot[i]) begin
        selected = payloads[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      valid  <= 1'b0;
      winner <= '0;
    end else begin
      valid  <= |oneHot;
      winner <= selected;
    end
  end

endmodule

// File: design/partDecode.sv
`timescale 1ns/1ps
`include "character_consts.svh"

module partDecode (
  input  logic                     clk,
  input  logic                     rstN,
  input  logic                     enable,
  input  logic                     motionEn,
  input  characterPkg::pixelPos    pixel,
  input  characterPkg::pixelPos    currentCorner,
  input  characterPkg::pixelPos    initCorner,
  output characterPkg::partCorners corners,
  output characterPkg::pixelPos    pixelOut,
  output logic                     enableOut
);
  import characterPkg::*;

  localparam int XW = `SCREEN_X_BITS;
  localparam int YW = `SCREEN_Y_BITS;

  pixelPos    base;
  partCorners nextCorners;

  // offsets are truncated to the coordinate width, so a negative offset wraps on the add.
  function automatic pixelPos partOffset(partIndex part);
    pixelPos off;
    off = '0;
    case (part)
      head: begin
        off.x = XW'(`HEAD_OFF_X);
        off.y = YW'(`HEAD_OFF_Y);
      end
      body: begin
        off.x = XW'(`BODY_OFF_X);
        off.y = YW'(`BODY_OFF_Y);
      end
      armLeft: begin
        off.x = XW'(`ARM_L_OFF_X);
        off.y = YW'(`ARM_L_OFF_Y);
      end
      armRight: begin
        off.x = XW'(`ARM_R_OFF_X);
        off.y = YW'(`ARM_R_OFF_Y);
      end
      pants: begin
        off.x = XW'(`PANTS_OFF_X);
        off.y = YW'(`PANTS_OFF_Y);
      end
      default: off = '0;
    endcase
    return off;
  endfunction

  assign base = motionEn ? currentCorner : initCorner;

  always_comb begin
    pixelPos off;
    for (int i = 0; i < `PART_COUNT; i++) begin
      off = partOffset(partIndex'(i));
      nextCorners[i].x = base.x + off.x;
      nextCorners[i].y = base.y + off.y;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      enableOut <= 1'b0;
    end else begin
      enableOut <= enable;
    end
  end

  always_ff @(posedge clk) begin
    corners  <= nextCorners;
    pixelOut <= pixel;
  end

endmodule

// File: design/partShape.sv
`timescale 1ns/1ps
`include "character_consts.svh"

module partShape (
  input  logic                     clk,
  input  logic                     rstN,
  input  logic                     enable,
  input  characterPkg::pixelPos    pixel,
  input  characterPkg::partCorners corners,
  output characterPkg::partHits    hits
);
  import characterPkg::*;

  localparam int XW = `SCREEN_X_BITS;
  localparam int YW = `SCREEN_Y_BITS;

  logic [`PART_COUNT-1:0] hitNext;

  // the size travels in a pixelPos, x holds the width and y the height.
  function automatic pixelPos partSize(partIndex part);
    pixelPos size;
    case (part)
      head:     size = '{x: XW'(`HEAD_W), y: YW'(`HEAD_H)};
      body:     size = '{x: XW'(`BODY_W), y: YW'(`BODY_H)};
      armLeft:  size = '{x: XW'(`ARM_L_W), y: YW'(`ARM_L_H)};
      armRight: size = '{x: XW'(`ARM_R_W), y: YW'(`ARM_R_H)};
      pants:    size = '{x: XW'(`PANTS_W), y: YW'(`PANTS_H)};
      default:  size = '0;
    endcase
    return size;
  endfunction

  function automatic rgbColor partColor(partIndex part);
    rgbColor color;
    case (part)
      head:     color = rgbColor'(`HEAD_RGB);
      body:     color = rgbColor'(`BODY_RGB);
      armLeft:  color = rgbColor'(`ARM_L_RGB);
      armRight: color = rgbColor'(`ARM_R_RGB);
      pants:    color = rgbColor'(`PANTS_RGB);
      default:  color = '0;
    endcase
    return color;
  endfunction

  // ######################################
  // rectangle test, the far edges are exclusive and one bit wider to avoid wrap.
  always_comb begin
    pixelPos      size;
    logic [XW:0]  xEnd;
    logic [YW:0]  yEnd;
    for (int i = 0; i < `PART_COUNT; i++) begin
      size = partSize(partIndex'(i));
      xEnd = {1'b0, corners[i].x} + {1'b0, size.x};
      yEnd = {1'b0, corners[i].y} + {1'b0, size.y};
      hitNext[i] = enable
                   && (pixel.x >= corners[i].x) && ({1'b0, pixel.x} < xEnd)
                   && (pixel.y >= corners[i].y) && ({1'b0, pixel.y} < yEnd);
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      hits <= '0;
    end else begin
      hits.hit <= hitNext;
      for (int i = 0; i < `PART_COUNT; i++) begin
        hits.color[i] <= partColor(partIndex'(i));
      end
    end
  end

endmodule

// File: run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root.
set -u

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
simName=characterRenderSim
logFile=sim.log

verilator --binary --timing -f compile.f --top-module characterRenderTb \
  --Mdir "$buildDir" -o "$simName"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$buildDir/$simName" > "$logFile" 2>&1
runStatus=$?
cat "$logFile"
if [ $runStatus -ne 0 ]; then
  echo "simulation exited with status $runStatus"
  exit 1
fi

# the testbench prints the fail line whenever a check or a wait went wrong.
if grep -q "Simulation failed" "$logFile"; then
  exit 1
fi
exit 0

// File: test/characterRenderTb.sv
`timescale 1ns/1ps

module characterRenderTb;
  import characterPkg::*;

  localparam int resetTimeout = 20;
  localparam int stimCycleLimit = 1000;
  localparam int drainTimeout = 10;

  // one expected result per driven cycle, oldest first.
  typedef struct packed {
    logic        check;
    logic        valid;
    logic [23:0] color;
    logic [15:0] lineNo;
  } expectEntry;

  logic       clk;
  logic       rstN;
  logic       enable;
  logic       motionEn;
  pixelPos    pixel;
  pixelPos    currentCorner;
  pixelPos    initCorner;
  shadedPixel out;

  expectEntry pipe[$];
  int         pendingChecks;
  int         checkCount;
  int         errorCount;

  characterRender dut (
    .clk          (clk),
    .rstN         (rstN),
    .enable       (enable),
    .motionEn     (motionEn),
    .pixel        (pixel),
    .currentCorner(currentCorner),
    .initCorner   (initCorner),
    .out          (out)
  );

  always #50 clk = ~clk;

  initial begin
    clk  = 1'b0;
    rstN = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;
  end

  task automatic compareValue(input string what, input logic [31:0] actual,
                              input logic [31:0] expected);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("[FAIL] %0t %s: got %h, expected %h", $time, what, actual, expected);
    end
  endtask

  // the result of a pixel is stable three falling edges after it was driven.
  task automatic checkOldest();
    expectEntry oldest;
    if (pipe.size() == 3) begin
      oldest = pipe.pop_front();
      if (oldest.check) begin
        pendingChecks--;
        compareValue($sformatf("line %0d valid", oldest.lineNo),
                     {31'b0, out.valid}, {31'b0, oldest.valid});
        compareValue($sformatf("line %0d color", oldest.lineNo),
                     {8'h0, out.color}, {8'h0, oldest.color});
      end
    end
  endtask

  // ######################################
  initial begin
    int          fd;
    int          status;
    int          fields;
    int          waitCycles;
    int          cycles;
    int          drainCycles;
    logic [15:0] lineNo;
    logic        aborted;
    string       line;
    logic        stimEn;
    logic        stimMotion;
    logic [9:0]  px;
    logic [8:0]  py;
    logic [9:0]  cx;
    logic [8:0]  cy;
    logic [9:0]  ix;
    logic [8:0]  iy;
    logic        expValid;
    logic [23:0] expColor;
    enable        = 1'b0;
    motionEn      = 1'b0;
    pixel         = '0;
    currentCorner = '0;
    initCorner    = '0;
    pendingChecks = 0;
    checkCount    = 0;
    errorCount    = 0;
    aborted       = 1'b0;
    lineNo        = 16'd0;
    cycles        = 0;

    fd = $fopen("test/render_stim.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file test/render_stim.txt");
      errorCount++;
      aborted = 1'b1;
    end

    waitCycles = 0;
    while (rstN !== 1'b1 && waitCycles < resetTimeout) begin
      @(posedge clk);
      waitCycles++;
    end
    if (rstN !== 1'b1) begin
      $display("reset was still asserted after %0d cycles", resetTimeout);
      errorCount++;
      aborted = 1'b1;
    end

    while (!aborted && cycles < stimCycleLimit) begin
      status = $fgets(line, fd);
      if (status == 0) break;
      lineNo++;
      if (line.len() < 2 || line.getc(0) == "#") continue;
      fields = $sscanf(line, "%d %d %d %d %d %d %d %d %d %h", stimEn, stimMotion,
                       px, py, cx, cy, ix, iy, expValid, expColor);
      if (fields == 0) continue;
      if (fields != 10) begin
        $display("stimulus line %0d could not be read: %s", lineNo, line);
        errorCount++;
        continue;
      end
      @(negedge clk);
      checkOldest();
      enable          = stimEn;
      motionEn        = stimMotion;
      pixel.x         = px;
      pixel.y         = py;
      currentCorner.x = cx;
      currentCorner.y = cy;
      initCorner.x    = ix;
      initCorner.y    = iy;
      pipe.push_back('{check: 1'b1, valid: expValid, color: expColor, lineNo: lineNo});
      pendingChecks++;
      cycles++;
    end
    if (!aborted && cycles >= stimCycleLimit) begin
      $display("the stimulus file ran past %0d pixels", stimCycleLimit);
      errorCount++;
    end
    if (!aborted && cycles == 0) begin
      $display("the stimulus file held no pixel lines");
      errorCount++;
    end

    // idle pixels push the last results out of the pipeline.
    drainCycles = 0;
    while (!aborted && pendingChecks > 0 && drainCycles < drainTimeout) begin
      @(negedge clk);
      checkOldest();
      enable = 1'b0;
      pipe.push_back('{check: 1'b0, valid: 1'b0, color: 24'h0, lineNo: 16'd0});
      drainCycles++;
    end
    if (!aborted && pendingChecks > 0) begin
      $display("%0d results never came out of the pipeline", pendingChecks);
      errorCount++;
    end

    if (fd != 0) $fclose(fd);
    $display("checks run: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: test/render_stim.txt
# enable motionEn pixelX pixelY curX curY initX initY expValid expColor
# coordinates in decimal, colour as RRGGBB hex, one pixel per clock cycle
# body only, initial placement
1 0 140 230 300 200 100 100 1 2e6fd8
# part edges around y offsets 95 to 104
1 0 150 199 300 200 100 100 1 f2c9a0
1 0 150 200 300 200 100 100 1 2e6fd8
1 0 95 197 300 200 100 100 1 e8b080
1 0 85 195 300 200 100 100 1 e8b080
1 0 84 195 300 200 100 100 0 000000
1 0 190 199 300 200 100 100 1 d89a6a
1 0 189 199 300 200 100 100 1 f2c9a0
1 0 204 244 300 200 100 100 1 d89a6a
1 0 204 245 300 200 100 100 0 000000
1 0 150 252 300 200 100 100 1 3a2a1c
1 0 150 291 300 200 100 100 1 3a2a1c
1 0 150 292 300 200 100 100 0 000000
# outside every part
1 0 50 50 300 200 100 100 0 000000
# placement select
1 0 320 320 300 200 100 100 0 000000
1 1 320 320 300 200 100 100 1 2e6fd8
1 1 140 230 300 200 100 100 0 000000
1 1 290 300 300 200 100 100 1 e8b080
1 1 390 300 300 200 100 100 1 d89a6a
1 1 350 360 300 200 100 100 1 3a2a1c
# enable low inside a part
0 0 140 230 300 200 100 100 0 000000
0 1 320 320 300 200 100 100 0 000000
# back to back, alternating hit and miss
1 0 140 230 300 200 100 100 1 2e6fd8
1 0 50 50 300 200 100 100 0 000000
1 0 150 150 300 200 100 100 1 f2c9a0
1 0 600 400 300 200 100 100 0 000000
1 0 95 200 300 200 100 100 1 e8b080
1 0 10 10 300 200 100 100 0 000000
